// ==== tests/serializer_vectors.txt ====
// Columns: cmd, metadata, dont_care_count, last (one hex digit each), then 8 data digits
// cmd 0 normal, 1 hold pop low, 2 hold pop low and change data on a stall, f end
010011223344
020155667788
0311a1b2c3d4
0421deadbeef
0531cafef00d
06200badf00d
070112345678
1100a0a0a0a0
1200b1b1b1b1
1300c2c2c2c2
1400d3d3d3d3
1500e4e4e4e4
1600f5f5f5f5
170006060606
101117171717
210029292929
230038383838
250047474747
02013a3a3a3a
f00000000000

// ==== vlog.f ====
+incdir+source
source/ser_pkg.sv
source/push_skid_buffer.sv
source/flit_fifo.sv
source/flow_serializer.sv
source/push_protocol_monitor.sv
source/serializer_top.sv
tests/serializer_checker.sv
tests/serializer_tb.sv

// ==== tests/serializer_tb.sv ====
// ##########################################################
// Serializer testbench
// Pushes the words of the vectors file, applies random and
// held pop back-pressure and reports the error counts
// ##########################################################

`timescale 1ns/10ps

module serializer_tb;

  localparam int max_vectors = 64;

  // Starts low before any process runs, so time zero brings no clock edge
  logic                 clk = 1'b0;
  logic                 rst_n;
  logic                 push_valid;
  ser_pkg::push_flit_t  push;
  logic                 push_ready;
  logic                 pop_valid;
  ser_pkg::pop_flit_t   pop;
  logic                 pop_ready;
  ser_pkg::mon_status_t status;

  // Each entry holds cmd, metadata, count and last nibbles, then the data word
  logic [47:0] vectors [max_vectors];
  int          vec_count;
  int          vec_idx;
  int          seed;
  int          checker_errors;
  int          pending;
  int          stim_errors;
  logic        hold_pop;
  logic        fell_seen;
  logic        count_known;

  serializer_top dut (
    .clk(clk), .rst_n(rst_n), .push_valid(push_valid), .push(push),
    .push_ready(push_ready), .pop_valid(pop_valid), .pop(pop),
    .pop_ready(pop_ready), .status(status)
  );

  serializer_checker chk (
    .clk(clk), .rst_n(rst_n), .push_valid(push_valid), .push_ready(push_ready),
    .push(push), .pop_valid(pop_valid), .pop_ready(pop_ready), .pop(pop),
    .status(status), .error_count(checker_errors), .pending(pending)
  );

  always #4 clk = ~clk;

  // Random pop back-pressure, forced low while a command holds the pop side
  always @(posedge clk) begin : pop_driver
    logic        hold_now;
    logic [31:0] rnd;
    hold_now = hold_pop;
    rnd      = $random(seed);
    #1;
    pop_ready = ~hold_now & (rnd[1:0] != 2'b00);
  end

  // Offers one word and keeps it until it is taken
  // A stall under a held pop side means the whole path is full, so the hold ends there
  task automatic send_word(input logic [47:0] vec);
    logic [3:0] cmd;
    logic       rdy;
    logic       done;
    cmd                  = vec[47:44];
    push.metadata        = vec[42:40];
    push.dont_care_count = vec[37:36];
    push.last            = vec[32];
    push.data            = vec[31:0];
    push_valid           = 1'b1;
    hold_pop             = (cmd != 4'h0);
    done                 = 1'b0;
    while (!done) begin
      rdy = push_ready;
      @(posedge clk);
      #1;
      if (rdy) begin
        done = 1'b1;
      end else if (hold_pop) begin
        fell_seen = 1'b1;
        // Breaks the stability rule on purpose
        if (cmd == 4'h2) begin
          push.data = push.data ^ 32'h00ff_00ff;
        end
        hold_pop = 1'b0;
      end
    end
  endtask

  initial begin
    rst_n       = 1'b0;
    push_valid  = 1'b0;
    push        = '0;
    pop_ready   = 1'b0;
    hold_pop    = 1'b0;
    fell_seen   = 1'b0;
    stim_errors = 0;
    seed        = 87;
    vec_count   = 0;
    count_known = 1'b0;
    $readmemh("tests/serializer_vectors.txt", vectors);
    while (vec_count < max_vectors && vectors[vec_count][47:44] !== 4'hf &&
           ^vectors[vec_count] !== 1'bx) begin
      vec_count++;
    end
    count_known = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (vec_idx = 0; vec_idx < vec_count; vec_idx++) begin
      send_word(vectors[vec_idx]);
    end
    push_valid = 1'b0;
    hold_pop   = 1'b0;
    while (pending != 0) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
    // The vectors hold both kinds of violation and one full-path stall
    if (status.unstable_payload !== 1'b1) begin
      $display("Fail status.unstable_payload expected 0x1 actual 0x%0h", status.unstable_payload);
      stim_errors++;
    end
    if (status.dont_care_not_last !== 1'b1) begin
      $display("Fail status.dont_care_not_last expected 0x1 actual 0x%0h",
               status.dont_care_not_last);
      stim_errors++;
    end
    if (!fell_seen) begin
      $display("push_ready never fell while the pop side was held low");
      stim_errors++;
    end
    $display("Errors: %0d from the checker, %0d from the stimulus", checker_errors, stim_errors);
    if (checker_errors + stim_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Allows about eight cycles a word plus a margin for reset and drain
  initial begin : watchdog
    wait (count_known);
    #((vec_count * 8 + 200) * 8);
    $display("The run timed out before every expected flit was popped");
    $display("Test failed");
    $finish;
  end

endmodule

// ==== tests/serializer_checker.sv ====
// ##########################################################
// Serializer checker
// Rebuilds the expected pop stream and monitor status from
// the handshakes on the DUT ports and counts mismatches
// ##########################################################

`timescale 1ns/10ps

`include "ser_settings.svh"

module serializer_checker (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 push_valid,
  input  logic                 push_ready,
  input  ser_pkg::push_flit_t  push,
  input  logic                 pop_valid,
  input  logic                 pop_ready,
  input  ser_pkg::pop_flit_t   pop,
  input  ser_pkg::mon_status_t status,
  output int                   error_count,
  output int                   pending
);

  ser_pkg::pop_flit_t   expected [$];
  ser_pkg::pop_flit_t   want;
  ser_pkg::pop_flit_t   held_pop;
  ser_pkg::push_flit_t  prev_push;
  ser_pkg::mon_status_t exp_status;
  logic                 prev_valid;
  logic                 prev_ready;
  logic                 pop_stalled;
  logic                 unstable_now;
  logic                 dont_care_now;

  initial begin
    error_count = 0;
    pending     = 0;
  end

  task automatic compare_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
    if (exp_val !== act_val) begin
      $display("Fail %s expected 0x%0h actual 0x%0h at %0t", name, exp_val, act_val, $time);
      error_count++;
    end
  endtask

  // A last word drops its trailing don't-care flits, every other word sends all of them
  task automatic add_word(input ser_pkg::push_flit_t w);
    int                 n;
    int                 i;
    int                 slice;
    ser_pkg::pop_flit_t f;
    n = w.last ? (`SER_RATIO - w.dont_care_count) : `SER_RATIO;
    for (i = 0; i < n; i++) begin
      slice      = `SER_MSB_FIRST ? (`SER_RATIO - 1 - i) : i;
      f.data     = w.data[slice * `SER_POP_WIDTH +: `SER_POP_WIDTH];
      f.last     = w.last && (i == n - 1);
      f.metadata = w.metadata;
      expected.push_back(f);
    end
  endtask

  // Sampled mid-cycle, where inputs and outputs have settled
  // A handshake seen here completes on the next rising edge
  always @(negedge clk) begin
    if (!rst_n) begin
      compare_value("push_ready", 32'h0, push_ready);
      compare_value("pop_valid", 32'h0, pop_valid);
      compare_value("status", 32'h0, status);
      exp_status  = '0;
      prev_valid  = 1'b0;
      prev_ready  = 1'b0;
      pop_stalled = 1'b0;
      expected.delete();
    end else begin
      // Status shows the violations of every cycle before this one
      compare_value("status", exp_status, status);
      // A stalled pop flit must stay offered and unchanged
      if (pop_stalled) begin
        compare_value("pop_valid", 32'h1, pop_valid);
        compare_value("pop", held_pop, pop);
      end
      if (pop_valid && pop_ready) begin
        if (expected.size() == 0) begin
          $display("A pop flit was transferred at %0t with none expected", $time);
          error_count++;
        end else begin
          want = expected.pop_front();
          compare_value("pop.data", want.data, pop.data);
          compare_value("pop.last", want.last, pop.last);
          compare_value("pop.metadata", want.metadata, pop.metadata);
        end
      end
      pop_stalled = pop_valid & ~pop_ready;
      held_pop    = pop;
      if (push_valid && push_ready) begin
        add_word(push);
      end
      // Same rules the push port must obey, modelled from the port alone
      unstable_now  = prev_valid & ~prev_ready & (~push_valid | (push != prev_push));
      dont_care_now = push_valid & ~push.last & (push.dont_care_count != '0);
      if (unstable_now) begin
        exp_status.unstable_payload = 1'b1;
      end
      if (dont_care_now) begin
        exp_status.dont_care_not_last = 1'b1;
      end
      if ((unstable_now || dont_care_now) && exp_status.violation_count != 8'hff) begin
        exp_status.violation_count = exp_status.violation_count + 8'h1;
      end
      prev_valid = push_valid;
      prev_ready = push_ready;
      prev_push  = push;
    end
    pending = expected.size();
  end

endmodule

// ==== source/serializer_top.sv ====
// ##########################################################
// Serializer top level
// Skid buffer, FIFO and serializer in a line from the push
// port to the pop port, with a monitor on the push port
// ##########################################################

`timescale 1ns/10ps

module serializer_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   push_valid,
  input  ser_pkg::push_flit_t    push,
  output logic                   push_ready,
  output logic                   pop_valid,
  output ser_pkg::pop_flit_t     pop,
  input  logic                   pop_ready,
  output ser_pkg::mon_status_t   status
);

  // Skid buffer to FIFO
  logic                skid_valid;
  logic                skid_ready;
  ser_pkg::push_flit_t skid;

  // FIFO to serializer
  logic                head_valid;
  logic                head_ready;
  ser_pkg::push_flit_t head;

  push_skid_buffer u_skid (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (push_valid),
    .push       (push),
    .push_ready (push_ready),
    .skid_valid (skid_valid),
    .skid       (skid),
    .skid_ready (skid_ready)
  );

  flit_fifo u_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .skid_valid (skid_valid),
    .skid       (skid),
    .skid_ready (skid_ready),
    .head_valid (head_valid),
    .head       (head),
    .head_ready (head_ready)
  );

  flow_serializer u_ser (
    .clk        (clk),
    .rst_n      (rst_n),
    .head_valid (head_valid),
    .head       (head),
    .head_ready (head_ready),
    .pop_valid  (pop_valid),
    .pop        (pop),
    .pop_ready  (pop_ready)
  );

  // Sees the same push port as the skid buffer
  push_protocol_monitor u_mon (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (push_valid),
    .push_ready (push_ready),
    .push       (push),
    .status     (status)
  );

endmodule

// ==== source/push_protocol_monitor.sv ====
// ##########################################################
// Push protocol monitor
// Watches the top push port for payload stability and
// don't-care count misuse, latching sticky status bits
// ##########################################################

`timescale 1ns/10ps

module push_protocol_monitor (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   push_valid,
  input  logic                   push_ready,
  input  ser_pkg::push_flit_t    push,
  output ser_pkg::mon_status_t   status
);

  // Last cycle's view of the push port
  logic                prev_valid;
  logic                prev_ready;
  ser_pkg::push_flit_t prev_push;

  ser_pkg::mon_status_t status_q;

  logic stalled;
  logic unstable_now;
  logic dont_care_now;
  logic any_violation;

  // A word was offered last cycle and not taken
  assign stalled = prev_valid & ~prev_ready;

  // A stalled word must come back with valid high and identical fields
  assign unstable_now = stalled & (~push_valid | (push != prev_push));

  // Only a last word may drop flits
  assign dont_care_now = push_valid & ~push.last & (push.dont_care_count != '0);

  assign any_violation = unstable_now | dont_care_now;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prev_valid <= 1'b0;
      prev_ready <= 1'b0;
    end else begin
      prev_valid <= push_valid;
      prev_ready <= push_ready;
    end
  end

  always_ff @(posedge clk) begin
    prev_push <= push;
  end

  // Flags are sticky, the counter holds at its top value
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      status_q <= '0;
    end else begin
      if (unstable_now) begin
        status_q.unstable_payload <= 1'b1;
      end
      if (dont_care_now) begin
        status_q.dont_care_not_last <= 1'b1;
      end
      if (any_violation && !(&status_q.violation_count)) begin
        status_q.violation_count <= status_q.violation_count + 1'b1;
      end
    end
  end

  assign status = status_q;

endmodule

// ==== source/flow_serializer.sv ====
// ##########################################################
// Flow serializer
// Cuts each buffered push word into narrow pop flits, drops
// don't-care flits of a last word and copies the metadata
// ##########################################################

`timescale 1ns/10ps

`include "ser_settings.svh"

module flow_serializer (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   head_valid,
  input  ser_pkg::push_flit_t    head,
  output logic                   head_ready,
  output logic                   pop_valid,
  output ser_pkg::pop_flit_t     pop,
  input  logic                   pop_ready
);

  // Index of the final flit of a full word
  localparam logic [`SER_CNT_WIDTH-1:0] max_idx = `SER_CNT_WIDTH'(`SER_RATIO - 1);

  ser_pkg::ser_state_e state;
  ser_pkg::ser_state_e state_next;

  logic [`SER_CNT_WIDTH-1:0] idx;
  logic [`SER_CNT_WIDTH-1:0] idx_next;
  logic [`SER_CNT_WIDTH-1:0] care_max;
  logic [`SER_CNT_WIDTH-1:0] sel;
  logic                      pop_xfer;
  logic                      last_flit;

  // A last word stops early by its don't-care count, other words send all flits
  assign care_max = head.last ? (max_idx - head.dont_care_count) : max_idx;

  assign last_flit = (idx == care_max);

  // The pop side is valid whenever a head word is waiting
  assign pop_valid = head_valid;
  assign pop_xfer  = head_valid & pop_ready;

  // The head word is released only as its final counted flit leaves
  assign head_ready = pop_xfer & last_flit;

  // Slice position within the word, reversed for most significant first
  always_comb begin
    if (`SER_MSB_FIRST) begin
      sel = max_idx - idx;
    end else begin
      sel = idx;
    end
  end

  always_comb begin
    pop.data     = head.data[sel * `SER_POP_WIDTH +: `SER_POP_WIDTH];
    pop.last     = head.last & last_flit;
    pop.metadata = head.metadata;
  end

  always_comb begin
    state_next = state;
    idx_next   = idx;
    case (state)
      ser_pkg::ser_idle: begin
        if (pop_xfer && !last_flit) begin
          // First flit of a multi-flit word has gone
          idx_next   = idx + 1'b1;
          state_next = ser_pkg::ser_sending;
        end
      end
      ser_pkg::ser_sending: begin
        if (pop_xfer) begin
          if (last_flit) begin
            idx_next   = '0;
            state_next = ser_pkg::ser_idle;
          end else begin
            idx_next = idx + 1'b1;
          end
        end
      end
      default: begin
        idx_next   = '0;
        state_next = ser_pkg::ser_idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ser_pkg::ser_idle;
      idx   <= '0;
    end else begin
      state <= state_next;
      idx   <= idx_next;
    end
  end

endmodule

// ==== source/flit_fifo.sv ====
// ##########################################################
// Flit FIFO
// Circular buffer of whole push words between the skid
// buffer and the serializer, one write and one read a cycle
// ##########################################################

`timescale 1ns/10ps

`include "ser_settings.svh"

module flit_fifo (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   skid_valid,
  input  ser_pkg::push_flit_t    skid,
  output logic                   skid_ready,
  output logic                   head_valid,
  output ser_pkg::push_flit_t    head,
  input  logic                   head_ready
);

  localparam int ptr_width = $clog2(`SER_FIFO_DEPTH);
  localparam int cnt_width = $clog2(`SER_FIFO_DEPTH + 1);

  // Highest slot index, where the pointers wrap back to zero
  localparam logic [ptr_width-1:0] last_slot = ptr_width'(`SER_FIFO_DEPTH - 1);
  localparam logic [cnt_width-1:0] full_count = cnt_width'(`SER_FIFO_DEPTH);

  ser_pkg::push_flit_t mem [`SER_FIFO_DEPTH];

  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  logic [cnt_width-1:0] count;
  logic                 wr_en;
  logic                 rd_en;

  // Full and empty both come straight from the occupancy count
  assign skid_ready = (count != full_count);
  assign head_valid = (count != '0);

  assign wr_en = skid_valid & skid_ready;
  assign rd_en = head_valid & head_ready;

  // Head is read from storage, so a write shows up a cycle later
  assign head = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= skid;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
      end
      // A write and a read in the same cycle leave the count alone
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== source/push_skid_buffer.sv ====
// ##########################################################
// Push skid buffer
// Takes push words at full rate behind a registered ready,
// holding one extra word in a skid register on a stall
// ##########################################################

`timescale 1ns/10ps

module push_skid_buffer (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   push_valid,
  input  ser_pkg::push_flit_t    push,
  output logic                   push_ready,
  output logic                   skid_valid,
  output ser_pkg::push_flit_t    skid,
  input  logic                   skid_ready
);

  // Main register feeds the output, skid register catches overflow
  ser_pkg::push_flit_t main_q;
  ser_pkg::push_flit_t skid_q;
  logic                main_valid;
  logic                skid_full;
  logic                ready_q;
  logic                push_xfer;
  logic                main_free;

  assign push_xfer = push_valid & ready_q;

  // The main register can load when it is empty or being drained now
  assign main_free = ~main_valid | skid_ready;

  // Control state
  // Ready only looks at the next skid occupancy, never at push_valid,
  // so it drops exactly when both entries hold a word
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      main_valid <= 1'b0;
      skid_full  <= 1'b0;
      ready_q    <= 1'b0;
    end else begin
      if (main_free) begin
        // A parked word always goes out before a new one
        main_valid <= skid_full | push_xfer;
        skid_full  <= 1'b0;
        ready_q    <= 1'b1;
      end else if (push_xfer) begin
        // Output stalled, park the new word in the skid entry
        skid_full <= 1'b1;
        ready_q   <= 1'b0;
      end else begin
        ready_q <= ~skid_full;
      end
    end
  end

  // Payload registers follow the same choice as the control above
  always_ff @(posedge clk) begin
    if (main_free) begin
      if (skid_full) begin
        main_q <= skid_q;
      end else if (push_xfer) begin
        main_q <= push;
      end
    end else if (push_xfer) begin
      skid_q <= push;
    end
  end

  assign push_ready = ready_q;
  assign skid_valid = main_valid;
  assign skid       = main_q;

endmodule

// ==== source/ser_pkg.sv ====
// ##########################################################
// Flow serializer package
// Flit structs, monitor status and serializer FSM states
// ##########################################################

`include "ser_settings.svh"

package ser_pkg;

  // One wide push word as it travels from the push port to the serializer
  // The don't-care count only matters on the final word of a packet
  typedef struct packed {
    // Payload, cut into SER_RATIO flits on the pop side
    logic [`SER_PUSH_WIDTH-1:0] data;
    // Marks the final word of a packet
    logic last;
    // Number of trailing flits to drop from a last word
    logic [`SER_CNT_WIDTH-1:0] dont_care_count;
    // Sideband field, not serialized
    logic [`SER_META_WIDTH-1:0] metadata;
  } push_flit_t;

  // One narrow flit on the pop port
  typedef struct packed {
    // Slice of the push word picked by the flit index
    logic [`SER_POP_WIDTH-1:0] data;
    // High only on the final counted flit of a last word
    logic last;
    // Same metadata as the push word it came from
    logic [`SER_META_WIDTH-1:0] metadata;
  } pop_flit_t;

  // Sticky violation flags and a saturating count of bad cycles
  // Everything here stays set until reset
  typedef struct packed {
    // A stalled push word changed, or valid dropped before transfer
    logic unstable_payload;
    // A valid non-last word carried a nonzero don't-care count
    logic dont_care_not_last;
    // Cycles with at least one violation, held at 255 once reached
    logic [7:0] violation_count;
  } mon_status_t;

  // Serializer FSM
  // The idle state waits on flit 0 of the head word, the sending state
  // is used once at least one flit of that word has gone out
  typedef enum logic {
    ser_idle,
    ser_sending
  } ser_state_e;

endpackage

// ==== source/ser_settings.svh ====
// ##########################################################
// Flow serializer settings
// Widths, FIFO depth and flit order shared by every block
// ##########################################################

`ifndef SER_SETTINGS_SVH
`define SER_SETTINGS_SVH

// Width of one push word, the wide side of the serializer
`define SER_PUSH_WIDTH 32

// Width of one pop flit, the narrow side
`define SER_POP_WIDTH 8

// Number of pop flits cut from one push word
`define SER_RATIO 4

// Holds a flit index from 0 to SER_RATIO - 1 and the don't-care count
`define SER_CNT_WIDTH 2

// Sideband metadata, copied untouched onto every pop flit
`define SER_META_WIDTH 3

// Buffer depth in whole push words
`define SER_FIFO_DEPTH 4

// 1 sends the most significant flit first, 0 the least significant
`define SER_MSB_FIRST 1

`endif
